// File: hw/rob_macros.svh
/*
 * Reorder buffer sizing and opcode encodings.
 * Opcodes are {primary opcode, funct} in MIPS style, 12 bits each.
 */
`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

`define ROB_DEPTH   16
`define ROB_PTR_W   4      // index into the entry array
`define ROB_TAG_W   5      // tags 1..16, 0 is none
`define DATA_W      32
`define OPC_W       12
`define REG_ADDR_W  5

`define OPC_ALU     12'h020   // r-type add
`define OPC_LW      12'h8C0
`define OPC_SW      12'hAC0
`define OPC_BEQ     12'h100
`define OPC_BNE     12'h140
`define OPC_J       12'h080
`define OPC_JAL     12'h0C0
`define OPC_JR      12'h008   // r-type, funct 08
`define OPC_HLT     12'hFC0

`endif

// File: hw/robPkg.sv
/*
 * Reorder buffer types.
 * Dispatch entry, CDB broadcast, head retire info and commit record.
 */
`default_nettype none

`include "rob_macros.svh"

package robPkg;

    typedef enum logic [1:0] {
        RK_NONE,
        RK_RETIRE,
        RK_MISPREDICT,
        RK_EXCEPT
    } retireKind_t;

    typedef struct packed {
        logic [`OPC_W-1:0]      opcode;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   isBranch;         // beq / bne
        logic                   predictTaken;
        logic                   readyAtDispatch;  // jal, hlt
        logic                   illegal;
        logic [`DATA_W-1:0]     redirectAddr;     // fetch target on a wrong guess
    } robEntry_t;

    typedef struct packed {
        logic                   valid;
        logic [`ROB_TAG_W-1:0]  tag;
        logic [`DATA_W-1:0]     data;
        logic                   exception;
        logic                   taken;            // branch outcome
    } cdbResult_t;

    typedef struct packed {
        retireKind_t            kind;
        logic [`OPC_W-1:0]      opcode;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`DATA_W-1:0]     data;
    } headInfo_t;

    typedef struct packed {
        logic                   valid;
        logic [`OPC_W-1:0]      opcode;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`DATA_W-1:0]     data;
        logic                   regWrite;
        logic                   memRead;
        logic                   memWrite;
    } commitInfo_t;

endpackage

`default_nettype wire

// File: hw/pipeStage.sv
/*
 * Valid/ready register stage with a one-entry skid register.
 * inReady comes straight from a flop, so the downstream ready
 * never reaches the upstream combinationally.
 */
`timescale 1ns/1ps
`default_nettype none

module pipeStage #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     inValid,
    input  payload_t inData,
    output logic     inReady,
    output logic     outValid,
    output payload_t outData,
    input  logic     outReady
);

    logic     mainValid;
    logic     skidValid;
    payload_t mainData;
    payload_t skidData;
    logic     inFire;
    logic     mainFree;

    assign inReady  = ~skidValid;          // room while skid is empty
    assign inFire   = inValid & inReady;
    assign mainFree = ~mainValid | outReady;
    assign outValid = mainValid;
    assign outData  = mainData;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mainValid <= 1'b0;
            skidValid <= 1'b0;
        end else if (mainFree) begin
            mainValid <= skidValid | inFire;   // skid drains first
            skidValid <= 1'b0;
        end else if (inFire) begin
            skidValid <= 1'b1;                 // main stalled, park it
        end
    end

    always_ff @(posedge clk) begin
        if (mainFree) begin
            mainData <= skidValid ? skidData : inData;
        end else if (inFire) begin
            skidData <= inData;
        end
    end

endmodule

`default_nettype wire

// File: hw/dispatchDecode.sv
/*
 * Dispatch decode.
 * Classifies the incoming opcode into a reorder buffer entry and
 * flags unknown opcodes. Handshake passes straight through.
 */
`timescale 1ns/1ps
`default_nettype none

`include "rob_macros.svh"

module dispatchDecode (
    input  logic                   dispatchValid,
    input  logic [`OPC_W-1:0]      dispatchOpcode,
    input  logic [`REG_ADDR_W-1:0] dispatchRd,
    input  logic                   dispatchPredict,
    input  logic [`DATA_W-1:0]     dispatchRedirect,
    output logic                   dispatchReady,
    output logic                   entryValid,
    output robPkg::robEntry_t      entry,
    input  logic                   entryReady
);

    logic isBranch;
    logic readyNow;
    logic illegal;

    always_comb begin
        isBranch = 1'b0;
        readyNow = 1'b0;
        illegal  = 1'b0;
        case (dispatchOpcode)
            `OPC_BEQ,
            `OPC_BNE: isBranch = 1'b1;
            `OPC_JAL,
            `OPC_HLT: readyNow = 1'b1;   // nothing to wait for on the CDB
            `OPC_ALU,
            `OPC_LW,
            `OPC_SW,
            `OPC_J,
            `OPC_JR: ;
            default: illegal = 1'b1;
        endcase
    end

    // prediction only matters for conditional branches
    always_comb begin
        entry.opcode          = dispatchOpcode;
        entry.rd              = dispatchRd;
        entry.isBranch        = isBranch;
        entry.predictTaken    = dispatchPredict & isBranch;
        entry.readyAtDispatch = readyNow;
        entry.illegal         = illegal;
        entry.redirectAddr    = dispatchRedirect;
    end

    assign entryValid    = dispatchValid;
    assign dispatchReady = entryReady;

endmodule

`default_nettype wire

// File: hw/reorderBuffer.sv
/*
 * Reorder buffer storage.
 * Circular array of 16 entries tagged 1..16. Allocates at the tail,
 * takes CDB results out of order, offers two operand read ports and
 * retires or flushes at the head.
 */
`timescale 1ns/1ps
`default_nettype none

`include "rob_macros.svh"

module reorderBuffer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   allocReq,
    input  robPkg::robEntry_t      allocEntry,
    output logic                   allocReady,
    output logic                   allocValid,
    output logic [`ROB_TAG_W-1:0]  allocTag,
    input  robPkg::cdbResult_t     cdb0,
    input  robPkg::cdbResult_t     cdb1,
    output robPkg::headInfo_t      head,
    input  logic [`ROB_TAG_W-1:0]  rdTag0,
    input  logic [`ROB_TAG_W-1:0]  rdTag1,
    output logic [`DATA_W-1:0]     rdData0,
    output logic [`DATA_W-1:0]     rdData1,
    output logic                   rdReady0,
    output logic                   rdReady1
);

    localparam logic [`ROB_TAG_W-1:0] DEPTH = `ROB_DEPTH;

    logic [`ROB_DEPTH-1:0]  busy;
    logic [`ROB_DEPTH-1:0]  ready;
    logic [`ROB_DEPTH-1:0]  spec;       // unresolved or wrongly guessed branch
    logic [`ROB_DEPTH-1:0]  excepted;
    logic [`ROB_DEPTH-1:0]  predict;
    logic [`OPC_W-1:0]      opcodeMem [`ROB_DEPTH];
    logic [`REG_ADDR_W-1:0] rdMem [`ROB_DEPTH];
    logic [`DATA_W-1:0]     dataMem [`ROB_DEPTH];

    logic [`ROB_PTR_W-1:0]  headPtr;
    logic [`ROB_PTR_W-1:0]  tailPtr;
    logic [`ROB_TAG_W-1:0]  count;
    logic                   full;
    logic                   flushing;
    logic                   flushHold;
    logic                   pop;
    robPkg::retireKind_t    headKind;

    logic [`ROB_PTR_W-1:0]  cdbIdx0;
    logic [`ROB_PTR_W-1:0]  cdbIdx1;
    logic                   cdbHit0;
    logic                   cdbHit1;
    logic [`ROB_PTR_W-1:0]  rdIdx0;
    logic [`ROB_PTR_W-1:0]  rdIdx1;

    // tag n lives at index n-1, tag 16 wraps to 15
    function automatic logic [`ROB_PTR_W-1:0] tagToIdx(input logic [`ROB_TAG_W-1:0] tag);
        logic [`ROB_TAG_W-1:0] diff;
        diff = tag - 1'b1;
        return diff[`ROB_PTR_W-1:0];
    endfunction

    always_comb begin
        headKind = robPkg::RK_NONE;
        if (busy[headPtr] && ready[headPtr]) begin
            if (excepted[headPtr]) begin
                headKind = robPkg::RK_EXCEPT;
            end else if (spec[headPtr]) begin
                headKind = robPkg::RK_MISPREDICT;   // resolved against the guess
            end else begin
                headKind = robPkg::RK_RETIRE;
            end
        end
    end

    assign head = '{kind: headKind, opcode: opcodeMem[headPtr], rd: rdMem[headPtr],
                    data: dataMem[headPtr]};

    assign flushing = (headKind == robPkg::RK_MISPREDICT) || (headKind == robPkg::RK_EXCEPT);
    assign pop      = (headKind == robPkg::RK_RETIRE);
    assign full     = (count == DEPTH);

    // no allocation while a flush is decided or being signalled
    assign allocReady = ~full & ~flushing & ~flushHold;
    assign allocValid = allocReq & allocReady;
    assign allocTag   = {1'b0, tailPtr} + 1'b1;

    assign cdbIdx0 = tagToIdx(cdb0.tag);
    assign cdbIdx1 = tagToIdx(cdb1.tag);
    assign cdbHit0 = cdb0.valid && (cdb0.tag != '0) && busy[cdbIdx0];
    assign cdbHit1 = cdb1.valid && (cdb1.tag != '0) && busy[cdbIdx1];

    assign rdIdx0   = tagToIdx(rdTag0);
    assign rdIdx1   = tagToIdx(rdTag1);
    assign rdData0  = dataMem[rdIdx0];
    assign rdData1  = dataMem[rdIdx1];
    assign rdReady0 = (rdTag0 != '0) && busy[rdIdx0] && ready[rdIdx0];
    assign rdReady1 = (rdTag1 != '0) && busy[rdIdx1] && ready[rdIdx1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= '0;
            ready     <= '0;
            spec      <= '0;
            excepted  <= '0;
            headPtr   <= '0;
            tailPtr   <= '0;
            count     <= '0;
            flushHold <= 1'b0;
        end else begin
            flushHold <= flushing;
            if (allocValid) begin
                busy[tailPtr]     <= 1'b1;
                ready[tailPtr]    <= allocEntry.readyAtDispatch | allocEntry.illegal;
                spec[tailPtr]     <= allocEntry.isBranch;
                excepted[tailPtr] <= allocEntry.illegal;
                tailPtr           <= tailPtr + 1'b1;
            end
            if (cdbHit0) begin
                ready[cdbIdx0]    <= 1'b1;
                excepted[cdbIdx0] <= cdb0.exception;
                spec[cdbIdx0]     <= spec[cdbIdx0] & (cdb0.taken ^ predict[cdbIdx0]);
            end
            if (cdbHit1) begin
                ready[cdbIdx1]    <= 1'b1;
                excepted[cdbIdx1] <= cdb1.exception;
                spec[cdbIdx1]     <= spec[cdbIdx1] & (cdb1.taken ^ predict[cdbIdx1]);
            end
            if (flushing) begin
                busy    <= '0;              // drop everything in flight
                headPtr <= '0;
                tailPtr <= '0;
                count   <= '0;
            end else begin
                if (pop) begin
                    busy[headPtr] <= 1'b0;
                    headPtr       <= headPtr + 1'b1;
                end
                count <= count + allocValid - pop;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (allocValid) begin
            opcodeMem[tailPtr] <= allocEntry.opcode;
            rdMem[tailPtr]     <= allocEntry.rd;
            dataMem[tailPtr]   <= allocEntry.redirectAddr;
            predict[tailPtr]   <= allocEntry.predictTaken;
        end
        // branches keep their redirect address
        if (cdbHit0 && !spec[cdbIdx0]) begin
            dataMem[cdbIdx0] <= cdb0.data;
        end
        if (cdbHit1 && !spec[cdbIdx1]) begin
            dataMem[cdbIdx1] <= cdb1.data;
        end
    end

endmodule

`default_nettype wire

// File: hw/commitUnit.sv
/*
 * Commit stage.
 * Registers the retiring head, decodes register file and memory
 * control bits, and pulses flush, redirect and exception.
 */
`timescale 1ns/1ps
`default_nettype none

`include "rob_macros.svh"

module commitUnit (
    input  logic                clk,
    input  logic                rst,
    input  robPkg::headInfo_t   head,
    output robPkg::commitInfo_t commit,
    output logic                flush,
    output logic                redirectValid,
    output logic [`DATA_W-1:0]  redirectAddr,
    output logic                exceptionFlag
);

    logic                   isRetire;
    logic                   isMispredict;
    logic                   isExcept;
    logic                   regWriteNext;
    logic                   validQ;
    logic                   regWriteQ;
    logic                   memReadQ;
    logic                   memWriteQ;
    logic [`OPC_W-1:0]      opcodeQ;
    logic [`REG_ADDR_W-1:0] rdQ;
    logic [`DATA_W-1:0]     dataQ;

    assign isRetire     = (head.kind == robPkg::RK_RETIRE);
    assign isMispredict = (head.kind == robPkg::RK_MISPREDICT);
    assign isExcept     = (head.kind == robPkg::RK_EXCEPT);

    // no destination register for these
    assign regWriteNext = !(head.opcode inside {`OPC_JR, `OPC_SW, `OPC_BEQ, `OPC_BNE, `OPC_J});

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            validQ        <= 1'b0;
            regWriteQ     <= 1'b0;
            memReadQ      <= 1'b0;
            memWriteQ     <= 1'b0;
            flush         <= 1'b0;
            redirectValid <= 1'b0;
            exceptionFlag <= 1'b0;
        end else begin
            validQ        <= isRetire;
            regWriteQ     <= isRetire & regWriteNext;
            memReadQ      <= isRetire & (head.opcode == `OPC_LW);
            memWriteQ     <= isRetire & (head.opcode == `OPC_SW);
            flush         <= isMispredict | isExcept;
            redirectValid <= isMispredict;
            exceptionFlag <= isExcept;
        end
    end

    always_ff @(posedge clk) begin
        if (head.kind != robPkg::RK_NONE) begin
            opcodeQ <= head.opcode;
            rdQ     <= head.rd;
            dataQ   <= head.data;     // result, or branch target on mispredict
        end
    end

    assign redirectAddr = dataQ;
    assign commit = '{valid: validQ, opcode: opcodeQ, rd: rdQ, data: dataQ,
                      regWrite: regWriteQ, memRead: memReadQ, memWrite: memWriteQ};

endmodule

`default_nettype wire

// File: hw/robTop.sv
/*
 * Reorder buffer subsystem top.
 * Dispatch decode, a registered stage, the buffer and the commit stage.
 */
`timescale 1ns/1ps
`default_nettype none

`include "rob_macros.svh"

module robTop (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   dispatchValid,
    input  logic [`OPC_W-1:0]      dispatchOpcode,
    input  logic [`REG_ADDR_W-1:0] dispatchRd,
    input  logic                   dispatchPredict,
    input  logic [`DATA_W-1:0]     dispatchRedirect,
    output logic                   dispatchReady,
    output logic                   allocValid,
    output logic [`ROB_TAG_W-1:0]  allocTag,
    input  robPkg::cdbResult_t     cdb0,
    input  robPkg::cdbResult_t     cdb1,
    input  logic [`ROB_TAG_W-1:0]  rdTag0,
    input  logic [`ROB_TAG_W-1:0]  rdTag1,
    output logic [`DATA_W-1:0]     rdData0,
    output logic [`DATA_W-1:0]     rdData1,
    output logic                   rdReady0,
    output logic                   rdReady1,
    output robPkg::commitInfo_t    commit,
    output logic                   flush,
    output logic                   redirectValid,
    output logic [`DATA_W-1:0]     redirectAddr,
    output logic                   exceptionFlag
);

    logic              entryValid;
    logic              entryReady;
    robPkg::robEntry_t entry;
    logic              stageValid;
    logic              stageReady;
    robPkg::robEntry_t stageEntry;
    robPkg::headInfo_t headInfo;

    dispatchDecode i_dispatchDecode (
        .dispatchValid(dispatchValid), .dispatchOpcode(dispatchOpcode),
        .dispatchRd(dispatchRd), .dispatchPredict(dispatchPredict),
        .dispatchRedirect(dispatchRedirect), .dispatchReady(dispatchReady),
        .entryValid(entryValid), .entry(entry), .entryReady(entryReady)
    );

    pipeStage #(.payload_t(robPkg::robEntry_t)) i_pipeStage (
        .clk(clk), .rst(rst),
        .inValid(entryValid), .inData(entry), .inReady(entryReady),
        .outValid(stageValid), .outData(stageEntry), .outReady(stageReady)
    );

    reorderBuffer i_reorderBuffer (
        .clk(clk), .rst(rst),
        .allocReq(stageValid), .allocEntry(stageEntry), .allocReady(stageReady),
        .allocValid(allocValid), .allocTag(allocTag),
        .cdb0(cdb0), .cdb1(cdb1), .head(headInfo),
        .rdTag0(rdTag0), .rdTag1(rdTag1), .rdData0(rdData0), .rdData1(rdData1),
        .rdReady0(rdReady0), .rdReady1(rdReady1)
    );

    commitUnit i_commitUnit (
        .clk(clk), .rst(rst), .head(headInfo), .commit(commit), .flush(flush),
        .redirectValid(redirectValid), .redirectAddr(redirectAddr),
        .exceptionFlag(exceptionFlag)
    );

endmodule

`default_nettype wire

// File: tests/robTop_props.sv
/*
 * Concurrent checks on the reorder buffer top, bound into robTop.
 * Covers commit against flush, allocation in a flush cycle, dispatch
 * hold while stalled and dispatch recovery after a flush.
 */
`timescale 1ns/1ps
`default_nettype none

`include "rob_macros.svh"

module robTop_props (
    input logic                   clk,
    input logic                   rst,
    input logic                   dispatchValid,
    input logic                   dispatchReady,
    input logic [`OPC_W-1:0]      dispatchOpcode,
    input logic [`REG_ADDR_W-1:0] dispatchRd,
    input logic                   dispatchPredict,
    input logic [`DATA_W-1:0]     dispatchRedirect,
    input logic                   allocValid,
    input robPkg::commitInfo_t    commit,
    input logic                   flush
);

    int failCount = 0;    // assertion failures so far

    commitNotFlush: assert property (@(posedge clk) disable iff (rst)
        !(commit.valid && flush))
        else begin
            failCount++;
            $error("commit and flush in the same cycle");
        end

    noAllocInFlush: assert property (@(posedge clk) disable iff (rst)
        !(allocValid && flush))
        else begin
            failCount++;
            $error("allocation during a flush cycle");
        end

    dispatchHeld: assert property (@(posedge clk) disable iff (rst)
        dispatchValid && !dispatchReady |=> dispatchValid && $stable(dispatchOpcode)
            && $stable(dispatchRd) && $stable(dispatchPredict) && $stable(dispatchRedirect))
        else begin
            failCount++;
            $error("dispatch inputs changed while stalled");
        end

    readyAfterFlush: assert property (@(posedge clk) disable iff (rst)
        flush |-> ##[1:2] dispatchReady)
        else begin
            failCount++;
            $error("dispatch not ready within two cycles of a flush");
        end

endmodule

bind robTop robTop_props i_robTop_props (
    .clk(clk), .rst(rst), .dispatchValid(dispatchValid), .dispatchReady(dispatchReady),
    .dispatchOpcode(dispatchOpcode), .dispatchRd(dispatchRd),
    .dispatchPredict(dispatchPredict), .dispatchRedirect(dispatchRedirect),
    .allocValid(allocValid), .commit(commit), .flush(flush)
);

`default_nettype wire

// File: tests/robTop_tb.sv
/*
 * Testbench for the reorder buffer subsystem.
 * Drives dispatch and CDB traffic and follows every allocation,
 * commit and flush with a model queue of tags in program order.
 */
`timescale 1ns/1ps
`default_nettype none

`include "rob_macros.svh"

module robTop_tb;

    logic                   clk;
    logic                   rst;
    logic                   dispatchValid;
    logic [`OPC_W-1:0]      dispatchOpcode;
    logic [`REG_ADDR_W-1:0] dispatchRd;
    logic                   dispatchPredict;
    logic [`DATA_W-1:0]     dispatchRedirect;
    logic                   dispatchReady;
    logic                   allocValid;
    logic [`ROB_TAG_W-1:0]  allocTag;
    robPkg::cdbResult_t     cdb0;
    robPkg::cdbResult_t     cdb1;
    logic [`ROB_TAG_W-1:0]  rdTag0;
    logic [`ROB_TAG_W-1:0]  rdTag1;
    logic [`DATA_W-1:0]     rdData0;
    logic [`DATA_W-1:0]     rdData1;
    logic                   rdReady0;
    logic                   rdReady1;
    robPkg::commitInfo_t    commit;
    logic                   flush;
    logic                   redirectValid;
    logic [`DATA_W-1:0]     redirectAddr;
    logic                   exceptionFlag;

    integer                 seed;
    int                     errors;
    int                     checks;
    logic [`ROB_TAG_W-1:0]  nextTag;                 // model allocation pointer
    logic [`ROB_TAG_W-1:0]  order[$];                // allocated tags, oldest first
    logic [`ROB_TAG_W-1:0]  tags[$];
    robPkg::robEntry_t      pending[$];              // accepted, not yet allocated
    robPkg::robEntry_t      mEnt [1:`ROB_DEPTH];
    logic [`DATA_W-1:0]     mData [1:`ROB_DEPTH];
    bit                     mKnown [1:`ROB_DEPTH];
    int                     mKind [1:`ROB_DEPTH];    // 0 retire, 1 mispredict, 2 except

    robTop i_robTop (.*);

    task automatic compare(input string name, input logic [`DATA_W-1:0] got,
                           input logic [`DATA_W-1:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic robPkg::robEntry_t expectEntry(input logic [`OPC_W-1:0] opc,
            input logic [`REG_ADDR_W-1:0] rd, input logic pred, input logic [`DATA_W-1:0] redir);
        robPkg::robEntry_t e;
        e = '0;
        e.opcode       = opc;
        e.rd           = rd;
        e.isBranch     = (opc == `OPC_BEQ) || (opc == `OPC_BNE);
        e.predictTaken = pred & e.isBranch;
        e.illegal      = !(opc inside {`OPC_ALU, `OPC_LW, `OPC_SW, `OPC_BEQ, `OPC_BNE,
                                       `OPC_J, `OPC_JAL, `OPC_JR, `OPC_HLT});
        e.redirectAddr = redir;
        return e;
    endfunction

    function automatic robPkg::cdbResult_t cdbWord(input logic [`ROB_TAG_W-1:0] tag,
            input logic [`DATA_W-1:0] data, input logic exc, input logic taken);
        return '{valid: 1'b1, tag: tag, data: data, exception: exc, taken: taken};
    endfunction

    function automatic logic [`DATA_W-1:0] tagData(input logic [`ROB_TAG_W-1:0] tag);
        return 32'hDA7A_0000 + tag;
    endfunction

    task automatic onAlloc();
        if (pending.size() == 0) begin
            errors++;
            $display("allocation at %0t without a dispatched instruction", $time);
        end else begin
            compare("allocTag", allocTag, nextTag);
            mEnt[nextTag]   = pending.pop_front();
            mKind[nextTag]  = mEnt[nextTag].illegal ? 2 : 0;
            mData[nextTag]  = mEnt[nextTag].redirectAddr;   // branches keep it
            mKnown[nextTag] = mEnt[nextTag].isBranch;
            order.push_back(nextTag);
            nextTag = (nextTag == `ROB_DEPTH) ? 1 : nextTag + 1'b1;
        end
    endtask

    task automatic applyCdb(input robPkg::cdbResult_t c);
        if (c.valid && c.tag != 0) begin
            if (c.exception) begin
                mKind[c.tag] = 2;
            end else if (mEnt[c.tag].isBranch && c.taken != mEnt[c.tag].predictTaken) begin
                mKind[c.tag] = 1;
            end else begin
                mKind[c.tag] = 0;
            end
            if (!mEnt[c.tag].isBranch) begin
                mData[c.tag]  = c.data;
                mKnown[c.tag] = 1'b1;
            end
        end
    endtask

    task automatic onCommit();
        logic [`ROB_TAG_W-1:0] t;
        logic [`OPC_W-1:0]     opc;
        if (order.size() == 0) begin
            errors++;
            $display("commit at %0t with no entry outstanding", $time);
        end else begin
            t   = order.pop_front();
            opc = mEnt[t].opcode;
            compare("commit.valid", 1'b1, mKind[t] == 0);
            compare("commit.opcode", commit.opcode, opc);
            compare("commit.rd", commit.rd, mEnt[t].rd);
            if (mKnown[t]) begin
                compare("commit.data", commit.data, mData[t]);
            end
            compare("commit.regWrite", commit.regWrite,
                    !(opc inside {`OPC_JR, `OPC_SW, `OPC_BEQ, `OPC_BNE, `OPC_J}));
            compare("commit.memRead", commit.memRead, opc == `OPC_LW);
            compare("commit.memWrite", commit.memWrite, opc == `OPC_SW);
        end
    endtask

    task automatic onFlush();
        logic [`ROB_TAG_W-1:0] t;
        if (order.size() == 0) begin
            errors++;
            $display("flush at %0t with no entry outstanding", $time);
        end else begin
            t = order[0];
            compare("flush", flush, mKind[t] != 0);
            compare("redirectValid", redirectValid, mKind[t] == 1);
            compare("exceptionFlag", exceptionFlag, mKind[t] == 2);
            if (mKind[t] == 1) begin
                compare("redirectAddr", redirectAddr, mEnt[t].redirectAddr);
            end
        end
        order.delete();
        nextTag = 1;    // buffer restarts empty
    endtask

    // pre-edge values, same edge the DUT acts on
    always @(posedge clk) begin
        if (!rst) begin
            if (flush) begin
                onFlush();
            end
            if (commit.valid) begin
                onCommit();
            end
            applyCdb(cdb0);
            applyCdb(cdb1);
            if (allocValid) begin
                onAlloc();
            end
            if (dispatchValid && dispatchReady) begin
                pending.push_back(expectEntry(dispatchOpcode, dispatchRd, dispatchPredict,
                                              dispatchRedirect));
            end
        end
    end

    task automatic dispatch(input logic [`OPC_W-1:0] opc, input logic [`REG_ADDR_W-1:0] rd,
                            input logic pred, input logic [`DATA_W-1:0] redir);
        int cycles;
        dispatchValid    = 1'b1;
        dispatchOpcode   = opc;
        dispatchRd       = rd;
        dispatchPredict  = pred;
        dispatchRedirect = redir;
        cycles = 0;
        while (!dispatchReady && cycles < 100) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!dispatchReady) begin
            errors++;
            $display("dispatch of opcode %h never accepted by %0t", opc, $time);
        end
        @(posedge clk);
        #1;
        dispatchValid = 1'b0;
    endtask

    task automatic broadcast(input robPkg::cdbResult_t a, input robPkg::cdbResult_t b);
        cdb0 = a;
        cdb1 = b;
        @(posedge clk);
        #1;
        cdb0 = '0;
        cdb1 = '0;
    endtask

    // wait until n entries are allocated and nothing is in flight before
    task automatic settle(input int n);
        int cycles;
        cycles = 0;
        while ((order.size() != n || pending.size() != 0) && cycles < 100) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (order.size() != n || pending.size() != 0) begin
            errors++;
            $display("timeout waiting for %0d outstanding entries at %0t", n, $time);
        end
    endtask

    // complete the head until everything has committed
    task automatic drainAll();
        int cycles;
        cycles = 0;
        while ((order.size() != 0 || pending.size() != 0) && cycles < 200) begin
            if (order.size() != 0) begin
                cdb0 = cdbWord(order[0], tagData(order[0]), 1'b0, 1'b0);
            end
            @(posedge clk);
            #1;
            cdb0 = '0;
            cycles++;
        end
        if (order.size() != 0 || pending.size() != 0) begin
            errors++;
            $display("timeout draining the buffer at %0t", $time);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        int j;
        logic [`ROB_TAG_W-1:0] t;
        seed = 32'h7978;
        errors = 0;
        checks = 0;
        nextTag = 1;
        rst = 1'b1;
        dispatchValid = 1'b0;
        dispatchOpcode = '0;
        dispatchRd = '0;
        dispatchPredict = 1'b0;
        dispatchRedirect = '0;
        cdb0 = '0;
        cdb1 = '0;
        rdTag0 = '0;
        rdTag1 = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        compare("dispatchReady", dispatchReady, 1'b1);
        compare("allocValid", allocValid, 1'b0);
        compare("commit.valid", commit.valid, 1'b0);
        compare("flush/redirect/exception", {flush, redirectValid, exceptionFlag}, 3'b000);

        // in-order commit of out-of-order results
        for (int i = 0; i < 6; i++) begin
            case (i % 3)
                0: dispatch(`OPC_ALU, 5'(i + 1), 1'b0, '0);
                1: dispatch(`OPC_LW, 5'(i + 1), 1'b0, '0);
                default: dispatch(`OPC_SW, 5'(i + 1), 1'b0, '0);
            endcase
        end
        settle(6);
        tags = order;
        for (int i = 5; i > 0; i--) begin
            j = $unsigned($random(seed)) % (i + 1);
            t = tags[i];
            tags[i] = tags[j];
            tags[j] = t;
        end
        for (int i = 0; i < 6; i += 2) begin
            broadcast(cdbWord(tags[i], $random(seed), 1'b0, 1'b0),
                      cdbWord(tags[i + 1], $random(seed), 1'b0, 1'b0));
        end
        settle(0);

        // control bits, jal and hlt need no result
        dispatch(`OPC_J, 5'd0, 1'b0, 32'h100);
        dispatch(`OPC_JR, 5'd0, 1'b0, 32'h104);
        dispatch(`OPC_BEQ, 5'd0, 1'b0, 32'h108);
        dispatch(`OPC_BNE, 5'd0, 1'b1, 32'h10C);
        dispatch(`OPC_JAL, 5'd31, 1'b0, 32'h110);
        dispatch(`OPC_HLT, 5'd0, 1'b0, 32'h114);
        settle(6);
        tags = order;
        broadcast(cdbWord(tags[0], tagData(tags[0]), 1'b0, 1'b0),
                  cdbWord(tags[1], tagData(tags[1]), 1'b0, 1'b0));
        broadcast(cdbWord(tags[2], 32'h0, 1'b0, 1'b0), cdbWord(tags[3], 32'h0, 1'b0, 1'b1));
        settle(0);

        // wrong guess on beq flushes the younger entries
        dispatch(`OPC_BEQ, 5'd0, 1'b1, 32'h0000_0400);
        dispatch(`OPC_ALU, 5'd3, 1'b0, '0);
        dispatch(`OPC_ALU, 5'd4, 1'b0, '0);
        settle(3);
        tags = order;
        broadcast(cdbWord(tags[1], 32'h11, 1'b0, 1'b0), cdbWord(tags[2], 32'h22, 1'b0, 1'b0));
        broadcast(cdbWord(tags[0], 32'h99, 1'b0, 1'b0), '0);
        settle(0);
        dispatch(`OPC_ALU, 5'd5, 1'b0, '0);
        settle(1);
        drainAll();

        // excepted result, then an unknown opcode
        dispatch(`OPC_LW, 5'd8, 1'b0, '0);
        dispatch(`OPC_ALU, 5'd9, 1'b0, '0);
        settle(2);
        tags = order;
        broadcast(cdbWord(tags[0], 32'hBAD, 1'b1, 1'b0), cdbWord(tags[1], 32'h5, 1'b0, 1'b0));
        settle(0);
        dispatch(12'h123, 5'd1, 1'b0, '0);
        settle(0);

        // fill the buffer, two more wait in the stage
        for (int i = 0; i < 18; i++) begin
            dispatch(`OPC_ALU, 5'(i), 1'b0, '0);
        end
        dispatchValid = 1'b1;
        dispatchOpcode = `OPC_ALU;
        dispatchRd = 5'd19;
        repeat (8) @(posedge clk);
        #1;
        compare("entries held", order.size(), `ROB_DEPTH);
        compare("entries waiting", pending.size(), 2);
        compare("dispatchReady while full", dispatchReady, 1'b0);
        broadcast(cdbWord(order[0], tagData(order[0]), 1'b0, 1'b0), '0);
        dispatch(`OPC_ALU, 5'd19, 1'b0, '0);
        drainAll();

        // operand read ports
        dispatch(`OPC_ALU, 5'd6, 1'b0, '0);
        dispatch(`OPC_ALU, 5'd7, 1'b0, '0);
        settle(2);
        tags = order;
        broadcast(cdbWord(tags[1], 32'h1234_5678, 1'b0, 1'b0), '0);
        rdTag0 = tags[1];
        rdTag1 = tags[0];
        #1;
        compare("rdReady0", rdReady0, 1'b1);
        compare("rdData0", rdData0, 32'h1234_5678);
        compare("rdReady1", rdReady1, 1'b0);
        rdTag0 = '0;
        rdTag1 = (tags[1] == `ROB_DEPTH) ? 1 : tags[1] + 1'b1;
        #1;
        compare("rdReady0", rdReady0, 1'b0);
        compare("rdReady1", rdReady1, 1'b0);
        rdTag0 = tags[0];
        rdTag1 = tags[1];
        #1;
        compare("rdReady0", rdReady0, 1'b0);
        compare("rdReady1", rdReady1, 1'b1);
        compare("rdData1", rdData1, 32'h1234_5678);
        drainAll();

        errors += i_robTop.i_robTop_props.failCount;
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hw
hw/robPkg.sv
hw/pipeStage.sv
hw/dispatchDecode.sv
hw/reorderBuffer.sv
hw/commitUnit.sv
hw/robTop.sv
tests/robTop_props.sv
tests/robTop_tb.sv
